// ==== rtl/fpadd_pkg.sv ====
// ==============================
// Shared types and constants of the single-precision adder pipeline
// Imported by every pipeline stage, the top level and the testbench
// ==============================

package fpadd_pkg;

    // ==============================
    // Format widths
    // ==============================

    // Biased exponent field of a single-precision number
    typedef logic [7:0]  exponent_t;

    // Stored fraction, the hidden bit is not part of it
    typedef logic [22:0] significand_t;

    // Fraction with the hidden bit on top
    typedef logic [23:0] mantissa_t;

    // Distance between the two exponents, used as the alignment shift
    typedef logic [7:0]  shift_t;

    // Number of leading zeros in a mantissa, at most 24
    typedef logic [4:0]  lz_count_t;

    typedef struct packed {
        logic         sign;
        exponent_t    exponent;
        significand_t significand;
    } float32_t;

    // Second operand keeps its sign on FADD and has it flipped on FSUB
    typedef enum logic {
        FADD = 1'b0,
        FSUB = 1'b1
    } fpadd_uop_t;

    // Bits below the kept fraction, reported for a later rounding unit
    typedef struct packed {
        logic guard;
        logic round;
        logic sticky;
    } round_bits_t;

    // ==============================
    // Stage hand-offs
    // ==============================

    // Output of the alignment stages, the minor operand already shifted
    typedef struct packed {
        float32_t  major;
        logic      minor_sign;
        mantissa_t minor_mantissa;
        mantissa_t shifted_out;
    } aligned_t;

    // Output of the adder stage, fraction holds the magnitude of the sum
    typedef struct packed {
        float32_t  result;
        logic      hidden;
        logic      carry;
        mantissa_t shifted_out;
    } sum_t;

    // ==============================
    // Format constants
    // ==============================

    // A carry at this exponent cannot be absorbed and raises overflow
    localparam exponent_t EXP_MAX_FINITE = 8'd254;
    localparam exponent_t EXP_MIN_NORMAL = 8'd1;
    localparam exponent_t EXP_ALL_ONES   = 8'd255;

    // A shift this large moves the whole minor mantissa out of the window
    localparam shift_t    ALIGN_LIMIT    = 8'd48;

    // Enabled edges from an accepted input to its result
    localparam int        PIPE_DEPTH     = 4;

    // Quiet NaN placed on the result of an invalid operation
    localparam float32_t  CANONICAL_NAN  = 32'h7FC0_0000;

endpackage : fpadd_pkg

// ==== rtl/fpadd_special_path.sv ====
// ==============================
// Special-operand path of the adder
// Detects infinities and NaNs on the raw inputs and delays the invalid
// flag and the valid bit so that both line up with the datapath result
// ==============================

`timescale 1ns/10ps

module fpadd_special_path import fpadd_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       clk_en_i,
    input  logic       data_valid_i,
    input  fpadd_uop_t operation_i,
    input  float32_t   addend_a_i,
    input  float32_t   addend_b_i,
    output logic       valid_o,
    output logic       invalid_o
);

    logic is_inf_a, is_inf_b;
    logic is_nan_a, is_nan_b;
    logic sign_b_eff;
    logic invalid;

    logic [PIPE_DEPTH-1:0] valid_pipe;
    logic [PIPE_DEPTH-1:0] invalid_pipe;

    // All-ones exponent marks a special value, the fraction tells which one
    assign is_inf_a = (addend_a_i.exponent == EXP_ALL_ONES) && (addend_a_i.significand == '0);
    assign is_inf_b = (addend_b_i.exponent == EXP_ALL_ONES) && (addend_b_i.significand == '0);
    assign is_nan_a = (addend_a_i.exponent == EXP_ALL_ONES) && (addend_a_i.significand != '0);
    assign is_nan_b = (addend_b_i.exponent == EXP_ALL_ONES) && (addend_b_i.significand != '0);

    // Sign of B as the datapath sees it
    assign sign_b_eff = addend_b_i.sign ^ (operation_i == FSUB);

    // Any NaN, or infinities of opposite sign meeting in the adder
    assign invalid = is_nan_a || is_nan_b
                  || (is_inf_a && is_inf_b && (addend_a_i.sign != sign_b_eff));

    always_ff @(posedge clk_i) begin : valid_shift
        if (!rst_n_i) begin
            valid_pipe <= '0;
        end else if (clk_en_i) begin
            valid_pipe <= {valid_pipe[PIPE_DEPTH-2:0], data_valid_i};
        end
    end : valid_shift

    // Flag pipe follows the valid bits, its content only matters when valid
    always_ff @(posedge clk_i) begin : invalid_shift
        if (clk_en_i) begin
            invalid_pipe <= {invalid_pipe[PIPE_DEPTH-2:0], invalid};
        end
    end : invalid_shift

    assign valid_o   = valid_pipe[PIPE_DEPTH-1];
    assign invalid_o = invalid_pipe[PIPE_DEPTH-1];

    // An accepted operation leaves after three further enabled edges
    valid_latency_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (clk_en_i && data_valid_i) |=> clk_en_i [->PIPE_DEPTH-1] ##1 valid_o);

endmodule : fpadd_special_path

// ==== rtl/fpadd_align.sv ====
// ==============================
// Operand compare and alignment, pipeline stages 0 and 1
// Stage 0 orders the operands by magnitude, stage 1 shifts the minor
// mantissa right so both operands share the major exponent
// ==============================

`timescale 1ns/10ps

module fpadd_align import fpadd_pkg::*; (
    input  logic       clk_i,
    input  logic       clk_en_i,
    input  fpadd_uop_t operation_i,
    input  float32_t   addend_a_i,
    input  float32_t   addend_b_i,
    output aligned_t   aligned_o
);

    // Subnormals are scaled like exponent 1, only their hidden bit differs
    function automatic exponent_t effective_exp(input exponent_t exp);
        return (exp == '0) ? EXP_MIN_NORMAL : exp;
    endfunction

    // ==============================
    // Stage 0, compare and swap
    // ==============================

    float32_t          addend_b;
    float32_t          major, minor;
    exponent_t         exp_a_eff, exp_b_eff;
    logic signed [8:0] exp_diff;
    shift_t            distance;

    // Subtraction is an addition with the sign of B inverted
    always_comb begin : sign_flip
        addend_b      = addend_b_i;
        addend_b.sign = addend_b_i.sign ^ (operation_i == FSUB);
    end : sign_flip

    assign exp_a_eff = effective_exp(addend_a_i.exponent);
    assign exp_b_eff = effective_exp(addend_b.exponent);
    assign exp_diff  = $signed({1'b0, exp_a_eff}) - $signed({1'b0, exp_b_eff});

    always_comb begin : swap
        if (exp_diff < 0) begin
            major    = addend_b;
            minor    = addend_a_i;
            distance = shift_t'(-exp_diff);
        end else begin
            // Equal exponents fall back on the fraction to find the larger one
            if ((exp_diff == 0) && (addend_a_i.significand < addend_b.significand)) begin
                major = addend_b;
                minor = addend_a_i;
            end else begin
                major = addend_a_i;
                minor = addend_b;
            end
            distance = shift_t'(exp_diff);
        end
    end : swap

    float32_t  major_stg0;
    shift_t    distance_stg0;
    logic      minor_sign_stg0;
    mantissa_t minor_mantissa_stg0;

    always_ff @(posedge clk_i) begin : stage0_reg
        if (clk_en_i) begin
            major_stg0          <= major;
            distance_stg0       <= distance;
            minor_sign_stg0     <= minor.sign;
            minor_mantissa_stg0 <= {minor.exponent != '0, minor.significand};
        end
    end : stage0_reg

    // ==============================
    // Stage 1, alignment shift
    // ==============================

    // Upper half lands under the major mantissa, lower half is what fell off
    logic [47:0] window;

    assign window = (distance_stg0 >= ALIGN_LIMIT) ? '0
                  : ({minor_mantissa_stg0, 24'b0} >> distance_stg0);

    always_ff @(posedge clk_i) begin : stage1_reg
        if (clk_en_i) begin
            aligned_o.major          <= major_stg0;
            aligned_o.minor_sign     <= minor_sign_stg0;
            aligned_o.minor_mantissa <= window[47:24];
            aligned_o.shifted_out    <= window[23:0];
        end
    end : stage1_reg

    // The swap must leave the larger scale on the major side
    major_exp_a : assert property (@(posedge clk_i)
        clk_en_i |=> effective_exp(major_stg0.exponent)
                     >= $past(effective_exp(minor.exponent)));

endmodule : fpadd_align

// ==== rtl/fpadd_significand_sum.sv ====
// ==============================
// Signed significand adder, pipeline stage 2
// Adds the aligned mantissas as two's complement values and returns
// the magnitude of the sum with the sign of the major operand
// ==============================

`timescale 1ns/10ps

module fpadd_significand_sum import fpadd_pkg::*; (
    input  logic     clk_i,
    input  logic     clk_en_i,
    input  aligned_t aligned_i,
    output sum_t     sum_o
);

    logic        major_hidden;
    logic [24:0] major_mag, minor_mag;
    logic [24:0] major_op, minor_op;
    logic [24:0] raw_sum;
    mantissa_t   magnitude;
    logic        negate;
    logic        same_sign;

    assign major_hidden = (aligned_i.major.exponent != '0);
    assign major_mag    = {1'b0, major_hidden, aligned_i.major.significand};
    assign minor_mag    = {1'b0, aligned_i.minor_mantissa};
    assign same_sign    = (aligned_i.major.sign == aligned_i.minor_sign);

    // Only the operand whose sign differs from the other gets negated
    always_comb begin : operand_sign
        major_op = major_mag;
        minor_op = minor_mag;
        negate   = 1'b0;
        case ({aligned_i.major.sign, aligned_i.minor_sign})
            2'b01: begin
                minor_op = -minor_mag;
            end
            2'b10: begin
                // Major is larger, so the sum is negative and is turned back
                major_op = -major_mag;
                negate   = 1'b1;
            end
            default: begin
                // Same signs add magnitudes, the sign is restored from the major
                negate   = 1'b0;
            end
        endcase
    end : operand_sign

    assign raw_sum   = major_op + minor_op;
    assign magnitude = negate ? -raw_sum[23:0] : raw_sum[23:0];

    always_ff @(posedge clk_i) begin : stage2_reg
        if (clk_en_i) begin
            sum_o.result.sign        <= aligned_i.major.sign;
            sum_o.result.exponent    <= aligned_i.major.exponent;
            sum_o.result.significand <= magnitude[22:0];
            sum_o.hidden             <= magnitude[23];
            // Bit 24 of a difference is a borrow, not a carry
            sum_o.carry              <= raw_sum[24] & same_sign;
            sum_o.shifted_out        <= aligned_i.shifted_out;
        end
    end : stage2_reg

endmodule : fpadd_significand_sum

// ==== rtl/fpadd_normalize.sv ====
// ==============================
// Normalization, pipeline stage 3
// Brings the sum back to a leading one, clamps the exponent on
// overflow and underflow and reports guard, round and sticky bits
// ==============================

`timescale 1ns/10ps

module fpadd_normalize import fpadd_pkg::*; (
    input  logic        clk_i,
    input  logic        clk_en_i,
    input  sum_t        sum_i,
    output float32_t    result_o,
    output logic        overflow_o,
    output logic        underflow_o,
    output round_bits_t round_bits_o
);

    mantissa_t   mantissa;
    lz_count_t   lz_count;
    logic        lz_found;
    logic [8:0]  exp_drop;
    exponent_t   min_shift;
    logic [47:0] window;
    float32_t    normalized;
    logic        overflow, underflow;
    round_bits_t round_bits;

    assign mantissa = {sum_i.hidden, sum_i.result.significand};

    // ==============================
    // Leading-zero count
    // ==============================

    always_comb begin : lzc
        lz_count = '0;
        lz_found = 1'b0;
        for (int i = 23; i >= 0; i--) begin
            if (mantissa[i]) begin
                lz_found = 1'b1;
            end else if (!lz_found) begin
                lz_count = lz_count + 1'b1;
            end
        end
    end : lzc

    // Borrow in bit 8 means the exponent would go below zero
    assign exp_drop = {1'b0, sum_i.result.exponent} - {4'b0, lz_count};

    // On underflow the shift only goes as far as the smallest normal exponent
    assign min_shift = (sum_i.result.exponent > EXP_MIN_NORMAL)
                     ? sum_i.result.exponent - EXP_MIN_NORMAL : '0;

    // ==============================
    // Normalization
    // ==============================

    always_comb begin : normalize
        normalized = sum_i.result;
        window     = '0;
        overflow   = 1'b0;
        underflow  = 1'b0;
        if (sum_i.carry) begin
            // Carry becomes the new hidden bit, so drop one bit at the bottom
            normalized.significand = mantissa[23:1];
            if (sum_i.result.exponent == EXP_MAX_FINITE) begin
                overflow = 1'b1;
            end else begin
                normalized.exponent = sum_i.result.exponent + 1'b1;
            end
        end else if (lz_count != '0) begin
            // Bits lost in the alignment are shifted back into the fraction
            if (exp_drop[8] || (exp_drop == '0)) begin
                normalized.exponent = EXP_MIN_NORMAL;
                window    = {mantissa, sum_i.shifted_out} << min_shift;
                underflow = 1'b1;
            end else begin
                normalized.exponent = exp_drop[7:0];
                window = {mantissa, sum_i.shifted_out} << lz_count;
            end
            normalized.significand = window[46:24];
        end
    end : normalize

    // Guard is the first bit below the kept fraction in every case
    always_comb begin : round_select
        if (sum_i.carry) begin
            round_bits.guard  = sum_i.result.significand[0];
            round_bits.round  = sum_i.shifted_out[23];
            round_bits.sticky = |sum_i.shifted_out[22:0];
        end else if (lz_count != '0) begin
            round_bits.guard  = window[23];
            round_bits.round  = window[22];
            round_bits.sticky = |window[21:0];
        end else begin
            round_bits.guard  = sum_i.shifted_out[23];
            round_bits.round  = sum_i.shifted_out[22];
            round_bits.sticky = |sum_i.shifted_out[21:0];
        end
    end : round_select

    always_ff @(posedge clk_i) begin : stage3_reg
        if (clk_en_i) begin
            result_o     <= normalized;
            overflow_o   <= overflow;
            underflow_o  <= underflow;
            round_bits_o <= round_bits;
        end
    end : stage3_reg

    // A carry and a leftward shift never happen on the same sum
    flags_exclusive_a : assert property (@(posedge clk_i)
        clk_en_i |=> !(overflow_o && underflow_o));

endmodule : fpadd_normalize

// ==== rtl/fp_adder.sv ====
// ==============================
// Four-stage single-precision adder and subtractor
// Takes one operand pair per enabled cycle, clk_en_i low freezes the
// whole pipeline, results come with their flags four enabled edges later
// ==============================

`timescale 1ns/10ps

module fp_adder import fpadd_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        clk_en_i,
    input  logic        data_valid_i,
    input  fpadd_uop_t  operation_i,
    input  float32_t    addend_a_i,
    input  float32_t    addend_b_i,
    output float32_t    result_o,
    output logic        data_valid_o,
    output logic        invalid_op_o,
    output logic        inexact_o,
    output logic        overflow_o,
    output logic        underflow_o,
    output round_bits_t round_bits_o
);

    aligned_t aligned;
    sum_t     sum;
    float32_t normalized;

    // Exceptions and the valid bit run beside the datapath
    fpadd_special_path special_path_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .clk_en_i     (clk_en_i),
        .data_valid_i (data_valid_i),
        .operation_i  (operation_i),
        .addend_a_i   (addend_a_i),
        .addend_b_i   (addend_b_i),
        .valid_o      (data_valid_o),
        .invalid_o    (invalid_op_o)
    );

    // ==============================
    // Significand datapath
    // ==============================

    fpadd_align align_inst (
        .clk_i       (clk_i),
        .clk_en_i    (clk_en_i),
        .operation_i (operation_i),
        .addend_a_i  (addend_a_i),
        .addend_b_i  (addend_b_i),
        .aligned_o   (aligned)
    );

    fpadd_significand_sum significand_sum_inst (
        .clk_i     (clk_i),
        .clk_en_i  (clk_en_i),
        .aligned_i (aligned),
        .sum_o     (sum)
    );

    fpadd_normalize normalize_inst (
        .clk_i        (clk_i),
        .clk_en_i     (clk_en_i),
        .sum_i        (sum),
        .result_o     (normalized),
        .overflow_o   (overflow_o),
        .underflow_o  (underflow_o),
        .round_bits_o (round_bits_o)
    );

    // Invalid operations hide whatever the datapath produced
    assign result_o  = invalid_op_o ? CANONICAL_NAN : normalized;

    // Any nonzero bit below the fraction means the sum was not exact
    assign inexact_o = |round_bits_o;

endmodule : fp_adder

// ==== tb/fp_adder_tb.sv ====
// ==============================
// Testbench of the four-stage floating-point adder
// Drives a table of operand pairs back to back under a random clock
// enable and checks every result against a queue of expected records
// ==============================

`timescale 1ns/10ps

module fp_adder_tb import fpadd_pkg::*; ();

    localparam int CLK_PERIOD     = 4;
    localparam int RESET_CYCLES   = 16;
    localparam int NUM_VECTORS    = 14;
    localparam int TIMEOUT_CYCLES = NUM_VECTORS * 20 + RESET_CYCLES;
    localparam int SEED           = 80542;

    // One row of the stimulus table with its expected response
    typedef struct packed {
        float32_t    addend_a;
        float32_t    addend_b;
        fpadd_uop_t  operation;
        float32_t    result;
        logic        invalid;
        logic        overflow;
        logic        underflow;
        logic        inexact;
        round_bits_t round_bits;
        logic [3:0]  en_pattern;
    } vector_t;

    // Operation in flight with the enabled edge that accepted it
    typedef struct packed {
        logic [7:0]  index;
        logic [31:0] accept_edge;
    } pending_t;

    logic        clk_i;
    logic        rst_n_i;
    logic        clk_en_i;
    logic        data_valid_i;
    fpadd_uop_t  operation_i;
    float32_t    addend_a_i;
    float32_t    addend_b_i;
    float32_t    result_o;
    logic        data_valid_o;
    logic        invalid_op_o;
    logic        inexact_o;
    logic        overflow_o;
    logic        underflow_o;
    round_bits_t round_bits_o;

    vector_t  vectors [NUM_VECTORS];
    string    names [NUM_VECTORS];
    int       table_size;
    int       issue_idx;
    int       enabled_edges;
    int       popped_count;
    pending_t expected_q [$];

    fp_adder fp_adder_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .clk_en_i     (clk_en_i),
        .data_valid_i (data_valid_i),
        .operation_i  (operation_i),
        .addend_a_i   (addend_a_i),
        .addend_b_i   (addend_b_i),
        .result_o     (result_o),
        .data_valid_o (data_valid_o),
        .invalid_op_o (invalid_op_o),
        .inexact_o    (inexact_o),
        .overflow_o   (overflow_o),
        .underflow_o  (underflow_o),
        .round_bits_o (round_bits_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Bounds the run by the longest stall sequence the table can produce
    initial begin : watchdog
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, not every result came back", TIMEOUT_CYCLES);
        $display("test failed");
        $fatal(1);
    end : watchdog

    // ==============================
    // Helpers
    // ==============================

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic add_vector(input string name, input float32_t a, input float32_t b,
                              input fpadd_uop_t op, input float32_t result,
                              input logic invalid, input logic overflow,
                              input logic underflow, input logic inexact,
                              input round_bits_t round_bits, input logic [3:0] en_pattern);
        names[table_size]   = name;
        vectors[table_size] = {a, b, op, result, invalid, overflow, underflow, inexact,
                               round_bits, en_pattern};
        table_size          = table_size + 1;
    endtask

    // Expected values follow from exact sums and the clamp and flag rules
    task automatic load_table();
        add_vector("add_1_2",         32'h3F80_0000, 32'h4000_0000, FADD,
                   32'h4040_0000, 1'b0, 1'b0, 1'b0, 1'b0, 3'b000, 4'b1111);
        add_vector("add_carry_1p5",   32'h3FC0_0000, 32'h3FC0_0000, FADD,
                   32'h4040_0000, 1'b0, 1'b0, 1'b0, 1'b0, 3'b000, 4'b0110);
        add_vector("sub_3_1",         32'h4040_0000, 32'h3F80_0000, FSUB,
                   32'h4000_0000, 1'b0, 1'b0, 1'b0, 1'b0, 3'b000, 4'b1111);
        add_vector("sub_normalize",   32'h3F80_0000, 32'h3FC0_0000, FSUB,
                   32'hBF00_0000, 1'b0, 1'b0, 1'b0, 1'b0, 3'b000, 4'b1000);
        add_vector("inf_sub_inf",     32'h7F80_0000, 32'h7F80_0000, FSUB,
                   32'h7FC0_0000, 1'b1, 1'b0, 1'b0, 1'b0, 3'b000, 4'b1111);
        add_vector("nan_add",         32'h7FA0_0000, 32'h3F80_0000, FADD,
                   32'h7FC0_0000, 1'b1, 1'b0, 1'b0, 1'b0, 3'b000, 4'b1010);
        add_vector("sub_nan",         32'h3F80_0000, 32'h7FA0_0000, FSUB,
                   32'h7FC0_0000, 1'b1, 1'b0, 1'b0, 1'b0, 3'b000, 4'b1111);
        add_vector("overflow_clamp",  32'h7F00_0000, 32'h7F00_0000, FADD,
                   32'h7F00_0000, 1'b0, 1'b1, 1'b0, 1'b0, 3'b000, 4'b0100);
        // Only sticky sees the 2^-30 bit, guard and round stay clear
        add_vector("inexact_sticky",  32'h3F80_0000, 32'h3080_0000, FADD,
                   32'h3F80_0000, 1'b0, 1'b0, 1'b0, 1'b1, 3'b001, 4'b1111);
        add_vector("add_neg",         32'hBF80_0000, 32'hC000_0000, FADD,
                   32'hC040_0000, 1'b0, 1'b0, 1'b0, 1'b0, 3'b000, 4'b0011);
        add_vector("add_swap_frac",   32'h3F80_0000, 32'h3FC0_0000, FADD,
                   32'h4020_0000, 1'b0, 1'b0, 1'b0, 1'b0, 3'b000, 4'b1111);
        // The 2^-23 bit drops out of the fraction right below the new LSB
        add_vector("carry_guard",     32'h3F80_0001, 32'h3F80_0000, FADD,
                   32'h4000_0000, 1'b0, 1'b0, 1'b0, 1'b1, 3'b100, 4'b1001);
        add_vector("inf_add_neg_inf", 32'h7F80_0000, 32'hFF80_0000, FADD,
                   32'h7FC0_0000, 1'b1, 1'b0, 1'b0, 1'b0, 3'b000, 4'b1111);
        add_vector("sub_exp_gap",     32'h4120_0000, 32'h3F80_0000, FSUB,
                   32'h4110_0000, 1'b0, 1'b0, 1'b0, 1'b0, 3'b000, 4'b0101);
    endtask

    // The pattern can force stalls on the first four cycles of a vector
    // and the random stream adds stalls on top of it
    function automatic logic pick_enable(input logic [3:0] pattern, input int step);
        logic random_ok;
        random_ok = ($urandom_range(3) != 0);
        if (step < 4) begin
            return pattern[step] & random_ok;
        end
        return random_ok;
    endfunction

    // Holds the operands on the inputs until an enabled edge takes them
    task automatic issue_vector(input int idx);
        int   step;
        logic en;
        step = 0;
        en   = 1'b0;
        while (!en) begin
            en   = pick_enable(vectors[idx].en_pattern, step);
            step = step + 1;
            @(posedge clk_i);
            addend_a_i   <= vectors[idx].addend_a;
            addend_b_i   <= vectors[idx].addend_b;
            operation_i  <= vectors[idx].operation;
            data_valid_i <= 1'b1;
            issue_idx    <= idx;
            clk_en_i     <= en;
        end
    endtask

    // ==============================
    // Scoreboard
    // ==============================

    // Only enabled edges move the pipeline, so only they accept or retire
    always @(posedge clk_i) begin : scoreboard
        pending_t pending;
        if (rst_n_i && clk_en_i) begin
            enabled_edges = enabled_edges + 1;
            if (data_valid_o) begin
                if (expected_q.size() == 0) begin
                    $display("Result appeared on data_valid_o with no operation in flight");
                    $display("test failed");
                    $fatal(1);
                end
                pending = expected_q.pop_front();
                check_value({names[pending.index], " latency"}, PIPE_DEPTH,
                            enabled_edges - pending.accept_edge);
                check_value({names[pending.index], " result"},
                            vectors[pending.index].result, result_o);
                check_value({names[pending.index], " invalid"},
                            vectors[pending.index].invalid, invalid_op_o);
                check_value({names[pending.index], " overflow"},
                            vectors[pending.index].overflow, overflow_o);
                check_value({names[pending.index], " underflow"},
                            vectors[pending.index].underflow, underflow_o);
                check_value({names[pending.index], " inexact"},
                            vectors[pending.index].inexact, inexact_o);
                check_value({names[pending.index], " round bits"},
                            vectors[pending.index].round_bits, round_bits_o);
                popped_count = popped_count + 1;
            end
            if (data_valid_i) begin
                pending.index       = issue_idx;
                pending.accept_edge = enabled_edges;
                expected_q.push_back(pending);
            end
        end
    end : scoreboard

    // ==============================
    // Main sequence
    // ==============================

    initial begin : stimulus
        void'($urandom(SEED));
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        clk_en_i      = 1'b1;
        data_valid_i  = 1'b0;
        operation_i   = FADD;
        addend_a_i    = '0;
        addend_b_i    = '0;
        issue_idx     = 0;
        table_size    = 0;
        enabled_edges = 0;
        popped_count  = 0;
        load_table();

        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;

        for (int idx = 0; idx < NUM_VECTORS; idx++) begin
            issue_vector(idx);
        end

        // Keep stalling randomly while the last operations drain
        do begin
            @(posedge clk_i);
            data_valid_i <= 1'b0;
            clk_en_i     <= pick_enable(4'b1111, 4);
            @(negedge clk_i);
        end while (popped_count < NUM_VECTORS);

        if ((expected_q.size() == 0) && (popped_count == NUM_VECTORS)) begin
            $display("test passed");
            $finish;
        end else begin
            $display("Scoreboard still holds %0d operations at the end", expected_q.size());
            $display("test failed");
            $fatal(1);
        end
    end : stimulus

endmodule : fp_adder_tb

// ==== list.f ====
rtl/fpadd_pkg.sv
rtl/fpadd_special_path.sv
rtl/fpadd_align.sv
rtl/fpadd_significand_sum.sv
rtl/fpadd_normalize.sv
rtl/fp_adder.sv
tb/fp_adder_tb.sv
